//--- hw/icache_pkg.sv
////////////////////////////////////////////////////////////
// shared geometry, types and command structs of the icache
// byte addresses, low two bits ignored on fetch
// line fills arrive whole, in a single return beat
////////////////////////////////////////////////////////////

package icache_pkg;

  //////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////
  localparam int NUM_WAYS = 2;
  localparam int NUM_SETS = 16;
  localparam int ADDR_W   = 32;
  localparam int FETCH_W  = 32;
  localparam int LINE_W   = 128;
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 4;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_W    = 1;

  // victim lfsr, seed must be non-zero
  localparam int          LFSR_W    = 8;
  localparam logic [7:0]  LFSR_SEED = 8'hA5;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [WAY_W-1:0]    way_t;
  typedef logic [NUM_WAYS-1:0] way_mask_t;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  typedef enum logic {RTRN_IFILL, RTRN_INV} rtrn_type_e;

  // line fill request, addr is line aligned
  typedef struct packed {
    addr_t addr;
    way_t  way;
  } fill_req_t;

  // refill port return beat
  typedef struct packed {
    rtrn_type_e rtype;
    line_t      data;
    index_t     inv_idx;
    way_t       inv_way;
    logic       inv_all;
  } rtrn_t;

  // controller -> arrays and selector
  typedef struct packed {
    logic      rd_en;
    logic      wr_en;
    logic      clr_en;
    index_t    index;
    way_mask_t clr_mask;
    way_t      wr_way;
    tag_t      tag;
  } array_cmd_t;

  // controller -> selector
  typedef struct packed {
    tag_t                tag;
    logic [OFFSET_W-3:0] word_off;
    logic                cmp_en;
  } lookup_t;

endpackage

//--- hw/icache_ctrl.sv
////////////////////////////////////////////////////////////
// icache request controller
// one fetch in flight, one outstanding line fill at most
// invals must not arrive while a fill is outstanding
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module icache_ctrl import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  logic       fetch_req_i,
  input  addr_t      fetch_addr_i,
  output logic       fetch_ready_o,
  output logic       fetch_valid_o,
  output logic       busy_o,
  output logic       mem_req_o,
  output fill_req_t  mem_req_data_o,
  input  logic       mem_ack_i,
  input  logic       mem_rtrn_vld_i,
  input  rtrn_t      mem_rtrn_i,
  input  logic       hit_i,
  input  way_t       repl_way_i,
  output array_cmd_t arr_cmd_o,
  output lookup_t    lookup_o
);

  state_e state_d, state_q;
  logic   flush_d, flush_q;
  index_t flush_cnt_d, flush_cnt_q;
  // set while the fill request waits for its ack
  logic   req_pend_d, req_pend_q;
  // an inval hit the arrays last cycle
  logic   inv_q;
  logic   inv_en;
  addr_t  addr_d, addr_q;
  way_t   fill_way_d, fill_way_q;
  tag_t   tag_q;
  index_t idx_q;

  assign tag_q  = addr_q[ADDR_W-1 -: TAG_W];
  assign idx_q  = addr_q[OFFSET_W +: INDEX_W];
  assign busy_o = (state_q != IDLE);

  // invals share the return port with fills
  assign inv_en = mem_rtrn_vld_i && (mem_rtrn_i.rtype == RTRN_INV);

  // compare only on a read not disturbed by an inval
  assign lookup_o.tag      = tag_q;
  assign lookup_o.word_off = addr_q[OFFSET_W-1:2];
  assign lookup_o.cmp_en   = (state_q == READ) && !inv_q && !inv_en;

  // way comes straight from the selector in the request cycle
  assign mem_req_data_o.addr = {tag_q, idx_q, {OFFSET_W{1'b0}}};
  assign mem_req_data_o.way  = (state_q == READ) ? repl_way_i : fill_way_q;

  ////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////
  always_comb begin : p_fsm
    state_d       = state_q;
    flush_d       = flush_q | flush_i;
    flush_cnt_d   = flush_cnt_q;
    req_pend_d    = req_pend_q & ~mem_ack_i;
    addr_d        = addr_q;
    fill_way_d    = fill_way_q;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = req_pend_q;

    arr_cmd_o          = '0;
    arr_cmd_o.index    = idx_q;
    arr_cmd_o.tag      = tag_q;
    arr_cmd_o.wr_way   = fill_way_q;

    // inval clears by mask, flush overrides it below
    if (inv_en) begin
      arr_cmd_o.clr_en = 1'b1;
      arr_cmd_o.index  = mem_rtrn_i.inv_idx;
      if (mem_rtrn_i.inv_all) begin
        arr_cmd_o.clr_mask = '1;
      end else begin
        arr_cmd_o.clr_mask = way_mask_t'(1) << mem_rtrn_i.inv_way;
      end
    end

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        arr_cmd_o.clr_en   = 1'b1;
        arr_cmd_o.index    = flush_cnt_q;
        arr_cmd_o.clr_mask = '1;
        flush_cnt_d        = flush_cnt_q + 1'b1;
        if (flush_cnt_q == index_t'(NUM_SETS-1)) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = !mem_rtrn_vld_i;
        end
      end
      READ: begin
        if (inv_en) begin
          // hold, the clear owns the index this cycle
          state_d = READ;
        end else if (inv_q) begin
          // valid bits may be stale, read again
          arr_cmd_o.rd_en = 1'b1;
        end else if (hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // next hit may follow directly
          fetch_ready_o = !flush_d && !mem_rtrn_vld_i;
        end else begin
          mem_req_o  = 1'b1;
          fill_way_d = repl_way_i;
          req_pend_d = !mem_ack_i;
          state_d    = MISS;
        end
      end
      MISS: begin
        // return word and write line in the same edge
        if (mem_rtrn_vld_i && (mem_rtrn_i.rtype == RTRN_IFILL)) begin
          fetch_valid_o   = 1'b1;
          arr_cmd_o.wr_en = 1'b1;
          state_d         = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase

    // accept a new fetch, read the whole set
    if (fetch_ready_o && fetch_req_i) begin
      addr_d          = fetch_addr_i;
      arr_cmd_o.rd_en = 1'b1;
      arr_cmd_o.index = fetch_addr_i[OFFSET_W +: INDEX_W];
      state_d         = READ;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      req_pend_q  <= 1'b0;
      inv_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      req_pend_q  <= req_pend_d;
      inv_q       <= inv_en;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin : p_payload
    addr_q     <= addr_d;
    fill_way_q <= fill_way_d;
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////
  a_legal_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache ctrl: illegal state");

endmodule

//--- hw/icache_arrays.sv
////////////////////////////////////////////////////////////
// icache tag, valid and line storage
// registered read of a whole set, outputs hold until next read
// write and clear are never issued together
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module icache_arrays import icache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  array_cmd_t               arr_cmd_i,
  input  line_t                    fill_line_i,
  output tag_t  [NUM_WAYS-1:0]     rd_tags_o,
  output way_mask_t                rd_valid_o,
  output line_t [NUM_WAYS-1:0]     rd_lines_o
);

  // storage, one entry per set and way
  tag_t      tag_mem  [NUM_SETS][NUM_WAYS];
  line_t     line_mem [NUM_SETS][NUM_WAYS];
  way_mask_t valid_q  [NUM_SETS];

  tag_t  [NUM_WAYS-1:0] rd_tags_q;
  line_t [NUM_WAYS-1:0] rd_lines_q;
  way_mask_t            rd_valid_q;

  ////////////////////////////////////////////////////////////
  // tag and line memories
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin : p_mem_wr
    // fill writes a single way
    if (arr_cmd_i.wr_en) begin
      tag_mem[arr_cmd_i.index][arr_cmd_i.wr_way]  <= arr_cmd_i.tag;
      line_mem[arr_cmd_i.index][arr_cmd_i.wr_way] <= fill_line_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_mem_rd
    if (arr_cmd_i.rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        rd_tags_q[w]  <= tag_mem[arr_cmd_i.index][w];
        rd_lines_q[w] <= line_mem[arr_cmd_i.index][w];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
      rd_valid_q <= '0;
    end else begin
      // clear by mask, from flush or inval
      if (arr_cmd_i.clr_en) begin
        valid_q[arr_cmd_i.index] <= valid_q[arr_cmd_i.index] & ~arr_cmd_i.clr_mask;
      end else if (arr_cmd_i.wr_en) begin
        valid_q[arr_cmd_i.index][arr_cmd_i.wr_way] <= 1'b1;
      end
      // read sees the bits before this edge's update
      if (arr_cmd_i.rd_en) begin
        rd_valid_q <= valid_q[arr_cmd_i.index];
      end
    end
  end

  assign rd_tags_o  = rd_tags_q;
  assign rd_valid_o = rd_valid_q;
  assign rd_lines_o = rd_lines_q;

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////
  // fills and invals share the return port
  a_no_wr_clr: assert property (
    @(posedge clk_i) disable iff (!rst_ni) arr_cmd_i.wr_en |-> !arr_cmd_i.clr_en)
    else $error("icache arrays: write and clear in the same cycle");

endmodule

//--- hw/icache_way_sel.sv
////////////////////////////////////////////////////////////
// tag compare, word select and victim choice
// data comes from the arrays on compare, else from the return
// lowest invalid way first, lfsr way once the set is full
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module icache_way_sel import icache_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  array_cmd_t           arr_cmd_i,
  input  lookup_t              lookup_i,
  input  tag_t  [NUM_WAYS-1:0] rd_tags_i,
  input  way_mask_t            rd_valid_i,
  input  line_t [NUM_WAYS-1:0] rd_lines_i,
  input  line_t                rtrn_line_i,
  output logic                 hit_o,
  output way_t                 repl_way_o,
  output logic [FETCH_W-1:0]   fetch_data_o
);

  way_mask_t         hit_vec;
  way_t              hit_way;
  way_t              inv_way;
  logic              all_valid;
  logic [LFSR_W-1:0] lfsr_q;
  line_t             sel_line;

  ////////////////////////////////////////////////////////////
  // hit generation
  ////////////////////////////////////////////////////////////
  always_comb begin : p_hit
    hit_vec = '0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = lookup_i.cmp_en && rd_valid_i[w] && (rd_tags_i[w] == lookup_i.tag);
    end
    // hits are one-hot, lowest wins anyway
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit_o = |hit_vec;

  // word from the hit way, or from the fill line on a miss
  assign sel_line     = lookup_i.cmp_en ? rd_lines_i[hit_way] : rtrn_line_i;
  assign fetch_data_o = sel_line[lookup_i.word_off*FETCH_W +: FETCH_W];

  ////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!rd_valid_i[w]) begin
        inv_way = way_t'(w);
      end
    end
  end

  assign all_valid  = &rd_valid_i;
  assign repl_way_o = all_valid ? lfsr_q[WAY_W-1:0] : inv_way;

  // x^8 + x^6 + x^5 + x^4 + 1, steps on a fill into a full set
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (arr_cmd_i.wr_en && all_valid) begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////
  // the controller never fills a line that is already present
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lookup_i.cmp_en |-> $onehot0(hit_vec))
    else $error("icache way sel: more than one way hits");

endmodule

//--- hw/icache_top.sv
////////////////////////////////////////////////////////////
// icache top level, single fetch port, single refill port
// refill returns are consumed unconditionally
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               fetch_req_i,
  input  addr_t              fetch_addr_i,
  output logic               fetch_ready_o,
  output logic               fetch_valid_o,
  output logic [FETCH_W-1:0] fetch_data_o,
  output logic               busy_o,
  output logic               mem_req_o,
  output fill_req_t          mem_req_data_o,
  input  logic               mem_ack_i,
  input  logic               mem_rtrn_vld_i,
  input  rtrn_t              mem_rtrn_i
);

  array_cmd_t           arr_cmd;
  lookup_t              lookup;
  logic                 hit;
  way_t                 repl_way;
  tag_t  [NUM_WAYS-1:0] rd_tags;
  way_mask_t            rd_valid;
  line_t [NUM_WAYS-1:0] rd_lines;

  icache_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .flush_i        ( flush_i        ),
    .fetch_req_i    ( fetch_req_i    ),
    .fetch_addr_i   ( fetch_addr_i   ),
    .fetch_ready_o  ( fetch_ready_o  ),
    .fetch_valid_o  ( fetch_valid_o  ),
    .busy_o         ( busy_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_req_data_o ( mem_req_data_o ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_i     ( mem_rtrn_i     ),
    .hit_i          ( hit            ),
    .repl_way_i     ( repl_way       ),
    .arr_cmd_o      ( arr_cmd        ),
    .lookup_o       ( lookup         )
  );

  // fill line goes straight from the return port
  icache_arrays i_arrays (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .arr_cmd_i   ( arr_cmd         ),
    .fill_line_i ( mem_rtrn_i.data ),
    .rd_tags_o   ( rd_tags         ),
    .rd_valid_o  ( rd_valid        ),
    .rd_lines_o  ( rd_lines        )
  );

  icache_way_sel i_way_sel (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .arr_cmd_i    ( arr_cmd         ),
    .lookup_i     ( lookup          ),
    .rd_tags_i    ( rd_tags         ),
    .rd_valid_i   ( rd_valid        ),
    .rd_lines_i   ( rd_lines        ),
    .rtrn_line_i  ( mem_rtrn_i.data ),
    .hit_o        ( hit             ),
    .repl_way_o   ( repl_way        ),
    .fetch_data_o ( fetch_data_o    )
  );

endmodule

//--- tb/icache_checker.sv
////////////////////////////////////////////////////////////
// icache port checker with a tag and valid model
// expects invals only while no fetch is in flight
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module icache_checker import icache_pkg::*; #(
  parameter logic [31:0] MIX_KEY = 32'h0
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               flush_i,
  input logic               fetch_req_i,
  input addr_t              fetch_addr_i,
  input logic               fetch_ready_o,
  input logic               fetch_valid_o,
  input logic [FETCH_W-1:0] fetch_data_o,
  input logic               mem_req_o,
  input fill_req_t          mem_req_data_o,
  input logic               mem_rtrn_vld_i,
  input rtrn_t              mem_rtrn_i
);

  tag_t   m_tag [NUM_SETS][NUM_WAYS];
  logic   m_vld [NUM_SETS][NUM_WAYS];
  int     errors, n_acc, n_valid, n_hit, n_miss;
  longint cyc, acc_cyc;
  bit     pend, exp_hit, req_seen, flush_pend;
  addr_t  p_addr;
  way_t   p_way;

  function automatic logic [31:0] exp_word(input addr_t a);
    return {a[31:2], 2'b00} ^ MIX_KEY;
  endfunction

  function automatic bit model_hit(input addr_t a);
    index_t x;
    bit     h;
    x = a[OFFSET_W +: INDEX_W];
    h = 0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_vld[x][w] && m_tag[x][w] == a[ADDR_W-1 -: TAG_W]) h = 1;
    end
    return h;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) m_vld[s][w] = 0;
    end
  endtask

  // sampled mid-cycle, all ports are settled
  always @(negedge clk_i) begin : p_check
    index_t x;
    int     low;
    if (!rst_ni) begin
      clear_model();
      pend       = 0;
      flush_pend = 0;
    end else begin
      cyc++;
      x = p_addr[OFFSET_W +: INDEX_W];
      if (fetch_valid_o) begin
        if (!pend) begin
          $display("fetch_valid_o pulsed without an accepted fetch");
          errors++;
        end else begin
          if (fetch_data_o !== exp_word(p_addr)) begin
            $display("MISMATCH fetch_data_o addr %h: got %h expected %h",
                     p_addr, fetch_data_o, exp_word(p_addr));
            errors++;
          end
          if (exp_hit && cyc != acc_cyc + 1) begin
            $display("hit at %h did not return one cycle after acceptance", p_addr);
            errors++;
          end
          if (!exp_hit && !req_seen) begin
            $display("miss at %h completed without a fill request", p_addr);
            errors++;
          end
          // a miss ends in the cycle of its fill return
          if (!exp_hit && !(mem_rtrn_vld_i && mem_rtrn_i.rtype == RTRN_IFILL)) begin
            $display("miss at %h did not complete in the cycle of its fill return", p_addr);
            errors++;
          end
          // a completed miss owns the chosen way now
          if (!exp_hit) begin
            m_tag[x][p_way] = p_addr[ADDR_W-1 -: TAG_W];
            m_vld[x][p_way] = 1;
          end
        end
        pend = 0;
        n_valid++;
      end
      if (mem_req_o && !req_seen) begin
        req_seen = 1;
        p_way    = mem_req_data_o.way;
        if (!pend || exp_hit) begin
          $display("fill request raised for a fetch that should hit or none at all");
          errors++;
        end else begin
          if (cyc != acc_cyc + 1) begin
            $display("fill request for %h not raised one cycle after acceptance", p_addr);
            errors++;
          end
          if (mem_req_data_o.addr !== {p_addr[ADDR_W-1:OFFSET_W], 4'h0}) begin
            $display("MISMATCH mem_req_data_o.addr: got %h expected %h",
                     mem_req_data_o.addr, {p_addr[ADDR_W-1:OFFSET_W], 4'h0});
            errors++;
          end
          // lowest invalid way first
          low = -1;
          for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!m_vld[x][w]) low = w;
          end
          if (low >= 0 && mem_req_data_o.way !== way_t'(low)) begin
            $display("MISMATCH mem_req_data_o.way: got %h expected %h",
                     mem_req_data_o.way, way_t'(low));
            errors++;
          end
        end
      end
      if (mem_rtrn_vld_i && mem_rtrn_i.rtype == RTRN_INV) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (mem_rtrn_i.inv_all || mem_rtrn_i.inv_way == way_t'(w)) begin
            m_vld[mem_rtrn_i.inv_idx][w] = 0;
          end
        end
      end
      if (flush_i) flush_pend = 1;
      // the flush runs once the fetch in flight is done
      if (flush_pend && !pend) begin
        clear_model();
        flush_pend = 0;
      end
      if (fetch_req_i && fetch_ready_o) begin
        if (pend) begin
          $display("fetch accepted while another is in flight");
          errors++;
        end
        pend     = 1;
        p_addr   = fetch_addr_i;
        acc_cyc  = cyc;
        exp_hit  = model_hit(fetch_addr_i);
        req_seen = 0;
        n_acc++;
        if (exp_hit) n_hit++;
        else n_miss++;
      end
    end
  end

endmodule

//--- tb/tb_icache.sv
////////////////////////////////////////////////////////////
// icache testbench with a refill memory responder
// fetches run one at a time, invals only when idle
// flushes when idle, one of them raised during a miss
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_icache import icache_pkg::*; ();

  localparam int          TMO     = 200;
  localparam logic [31:0] MIX_KEY = 32'h5a3c_96e1;

  logic               clk_i, rst_ni, flush_i, fetch_req_i;
  addr_t              fetch_addr_i;
  logic               fetch_ready_o, fetch_valid_o, busy_o, mem_req_o;
  logic               mem_ack_i, mem_rtrn_vld_i;
  logic [FETCH_W-1:0] fetch_data_o;
  fill_req_t          mem_req_data_o;
  rtrn_t              mem_rtrn_i;
  int                 seed, tb_errors, n_tests;
  tag_t               tag_pool [6];
  index_t             idx_pool [4];

  icache_top i_dut (.*);

  icache_checker #(.MIX_KEY(MIX_KEY)) i_chk (.*);

  always #50 clk_i = ~clk_i;

  // each word is its own address mixed with a key
  function automatic line_t make_line(input addr_t la);
    line_t l;
    for (int i = 0; i < 4; i++) l[i*32 +: 32] = (la + addr_t'(4 * i)) ^ MIX_KEY;
    return l;
  endfunction

  function automatic addr_t rand_addr();
    tag_t   t;
    index_t x;
    t = tag_pool[{$random(seed)} % 6];
    x = idx_pool[{$random(seed)} % 4];
    return {t, x, 4'({$random(seed)} % 16)};
  endfunction

  task automatic do_fetch(input addr_t a, input bit flush_in_miss);
    int t, ack_cnt, ret_cnt;
    bit acc, done, req_seen, acked, sent;
    t        = 0;
    acc      = 0;
    done     = 0;
    req_seen = 0;
    acked    = 0;
    sent     = 0;
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= a;
    while (!acc && t < TMO) begin
      @(posedge clk_i);
      t++;
      if (fetch_ready_o) begin
        acc = 1;
        fetch_req_i <= 1'b0;
      end
    end
    while (acc && !done && t < TMO) begin
      @(posedge clk_i);
      t++;
      flush_i        <= 1'b0;
      mem_ack_i      <= 1'b0;
      mem_rtrn_vld_i <= 1'b0;
      if (fetch_valid_o) begin
        done = 1;
      end else if (mem_req_o || req_seen) begin
        if (!req_seen) begin
          req_seen = 1;
          ack_cnt  = {$random(seed)} % 4;
          if (flush_in_miss) flush_i <= 1'b1;
        end
        if (!acked) begin
          if (ack_cnt == 0) begin
            mem_ack_i <= 1'b1;
            acked   = 1;
            ret_cnt = 1 + {$random(seed)} % 5;
          end else begin
            ack_cnt--;
          end
        end else if (!sent) begin
          ret_cnt--;
          if (ret_cnt == 0) begin
            sent = 1;
            mem_rtrn_vld_i   <= 1'b1;
            mem_rtrn_i.rtype <= RTRN_IFILL;
            mem_rtrn_i.data  <= make_line(mem_req_data_o.addr);
          end
        end
      end
    end
    fetch_req_i <= 1'b0;
    if (!done) begin
      $display("timeout waiting for the fetch of %h to complete", a);
      tb_errors++;
    end
  endtask

  task automatic send_inval(input index_t x, input way_t w, input logic all);
    @(posedge clk_i);
    mem_rtrn_vld_i     <= 1'b1;
    mem_rtrn_i.rtype   <= RTRN_INV;
    mem_rtrn_i.inv_idx <= x;
    mem_rtrn_i.inv_way <= w;
    mem_rtrn_i.inv_all <= all;
    @(posedge clk_i);
    mem_rtrn_vld_i <= 1'b0;
  endtask

  // busy must stay high for exactly one pass over the sets
  task automatic measure_flush();
    int t, n;
    t = 0;
    n = 0;
    @(negedge clk_i);
    while (!busy_o && t < TMO) begin
      @(negedge clk_i);
      t++;
    end
    while (busy_o && t < TMO) begin
      n++;
      @(negedge clk_i);
      t++;
    end
    if (t >= TMO) begin
      $display("timeout waiting for the flush to end");
      tb_errors++;
    end else if (n != NUM_SETS) begin
      $display("MISMATCH busy_o cycles: got %h expected %h", n, NUM_SETS);
      tb_errors++;
    end
  endtask

  task automatic flush_cache();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    measure_flush();
  endtask

  task automatic end_test(input string name, input int err_before);
    n_tests++;
    $display("test %s done, %0d errors", name, tb_errors + i_chk.errors - err_before);
  endtask

  initial begin : p_main
    int e0, r;
    seed = 32'hb4d6ecaf;
    tag_pool = '{24'h000012, 24'h0a5a01, 24'h3c0007, 24'h800100, 24'hfff0f0, 24'h123456};
    idx_pool = '{4'h0, 4'h3, 4'h7, 4'hc};
    clk_i          = 1'b0;
    rst_ni         <= 1'b0;
    flush_i        <= 1'b0;
    fetch_req_i    <= 1'b0;
    fetch_addr_i   <= '0;
    mem_ack_i      <= 1'b0;
    mem_rtrn_vld_i <= 1'b0;
    mem_rtrn_i     <= '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    e0 = 0;
    measure_flush();
    end_test("reset_flush", e0);

    e0 = tb_errors + i_chk.errors;
    for (int i = 0; i < 8; i++) do_fetch({tag_pool[i % 2], idx_pool[i % 4], 4'h4}, 0);
    end_test("cold_misses", e0);

    e0 = tb_errors + i_chk.errors;
    for (int i = 0; i < 8; i++) do_fetch({tag_pool[i % 2], idx_pool[i % 4], 4'hc}, 0);
    end_test("warm_hits", e0);

    // one way at one set, all ways at another
    e0 = tb_errors + i_chk.errors;
    send_inval(idx_pool[0], 1'b0, 1'b0);
    send_inval(idx_pool[1], 1'b0, 1'b1);
    for (int i = 0; i < 8; i++) do_fetch({tag_pool[i % 2], idx_pool[i % 4], 4'h8}, 0);
    end_test("inval", e0);

    e0 = tb_errors + i_chk.errors;
    for (int i = 0; i < 200; i++) begin
      r = {$random(seed)} % 20;
      if (r < 16) do_fetch(rand_addr(), 0);
      else if (r < 19) send_inval(idx_pool[{$random(seed)} % 4], way_t'($random(seed)),
                                  logic'($random(seed)));
      else flush_cache();
    end
    end_test("random_mix", e0);

    e0 = tb_errors + i_chk.errors;
    flush_cache();
    do_fetch({tag_pool[5], idx_pool[2], 4'h0}, 1);
    measure_flush();
    do_fetch({tag_pool[5], idx_pool[2], 4'h4}, 0);
    end_test("flush_in_miss", e0);

    repeat (2) @(posedge clk_i);
    if (i_chk.n_acc != i_chk.n_valid) begin
      $display("MISMATCH fetch_valid_o count: got %h expected %h", i_chk.n_valid, i_chk.n_acc);
      tb_errors++;
    end
    $display("tests %0d, fetches %0d, hits %0d, misses %0d, errors %0d", n_tests,
             i_chk.n_acc, i_chk.n_hit, i_chk.n_miss, tb_errors + i_chk.errors);
    if (tb_errors + i_chk.errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- project.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_arrays.sv
hw/icache_way_sel.sv
hw/icache_top.sv
tb/icache_checker.sv
tb/tb_icache.sv
